// File: sim.f
verilog/core_uarch_pkg.sv
verilog/core_decode_mux.sv
verilog/core_decode_snd.sv
verilog/core_decode_data.sv
verilog/core_decode_ldst_single.sv
verilog/core_decode_mul.sv
verilog/core_decode.sv
verilog/core_decode_stage.sv
dv/core_decode_props.sv
dv/core_decode_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module core_decode_tb -o core_decode_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/core_decode_sim > sim.log 2>&1
run_status=$?
cat sim.log

if [ $run_status -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// File: dv/core_decode_tb.sv
module core_decode_tb;

	import core_uarch_pkg::*;

	localparam int num_insns = 3000;
	localparam int clk_period = 40;

	typedef struct packed {
		insn_group group;
		cond_code cond;
		logic undefined;
		logic conditional;
		alu_op alu;
		reg_num rd;
		reg_num rn;
		reg_num rm;
		reg_num rs;
		logic is_imm;
		word imm_value;
		shift_op shift;
		logic [4:0] shift_imm;
		logic shift_by_reg;
		logic writeback;
		logic update_flags;
		word branch_offset;
		logic link;
		logic ldst_load;
		logic ldst_byte;
		logic ldst_up;
		logic ldst_pre;
		logic ldst_base_wb;
		logic mul_accumulate;
	} dec_fields;

	logic clk = 1'b0;
	logic rst_n;
	word insn;
	logic insn_valid, stall, insn_ready, dec_valid;
	insn_group group;
	cond_code cond;
	logic undefined, conditional;
	alu_op alu;
	reg_num rd, rn, rm, rs;
	logic is_imm;
	word imm_value;
	shift_op shift;
	logic [4:0] shift_imm;
	logic shift_by_reg, writeback, update_flags;
	word branch_offset;
	logic link, ldst_load, ldst_byte, ldst_up, ldst_pre, ldst_base_wb, mul_accumulate;

	word expected_q[$];
	int sent = 0;
	int checked = 0;

	core_decode_stage i_dut (.*);

	always #(clk_period / 2) clk = ~clk;

	task automatic check_value(input string field, input logic [31:0] got,
	                           input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, field, got, expected);
			$display("RESULT: FAIL");
			$fatal(1, "decoded field mismatch");
		end
	endtask

	function automatic dec_fields ref_decode(input word w);
		dec_fields e;
		logic [4:0] rot;
		word imm8;
		logic is_compare;
		e = '0;
		rot = {w[11:8], 1'b0};
		imm8 = 32'(w[7:0]);
		e.cond = w[31:28];
		e.conditional = w[31:28] != cond_al;
		if (w[31:28] == 4'hf)
			e.group = GROUP_UNDEF;
		else if (w[27:22] == 6'd0 && w[7:4] == 4'b1001)
			e.group = GROUP_MUL;
		else if (w[27:26] == 2'b00 && !(!w[25] && w[7] && w[4])
		         && !(w[24:23] == 2'b10 && !w[20]))
			e.group = GROUP_DATA;
		else if (w[27:26] == 2'b01 && !(w[25] && w[4]))
			e.group = GROUP_LDST;
		else if (w[27:25] == 3'b101)
			e.group = GROUP_BRANCH;
		else if (w[27:24] == 4'b1111)
			e.group = GROUP_SWI;
		else
			e.group = GROUP_UNDEF;
		e.undefined = e.group == GROUP_UNDEF;

		case (e.group)
			GROUP_DATA: begin
				is_compare = w[24:23] == 2'b10; // TST, TEQ, CMP and CMN.
				e.alu = alu_op'(w[24:21]);
				e.rn = w[19:16];
				e.rd = w[15:12];
				e.writeback = !is_compare;
				e.update_flags = w[20] | is_compare;
				e.is_imm = w[25];
				if (w[25]) begin
					e.imm_value = (imm8 >> rot) | (imm8 << (6'd32 - 6'(rot)));
				end else begin
					e.rm = w[3:0];
					e.shift = shift_op'(w[6:5]);
					e.shift_by_reg = w[4];
					if (w[4]) begin
						e.rs = w[11:8];
						e.undefined = w[3:0] == 4'hf || w[11:8] == 4'hf;
					end else begin
						e.shift_imm = w[11:7];
					end
				end
			end
			GROUP_LDST: begin
				e.rn = w[19:16];
				e.rd = w[15:12];
				e.writeback = w[20];
				e.ldst_load = w[20];
				e.ldst_byte = w[22];
				e.ldst_up = w[23];
				e.ldst_pre = w[24];
				e.ldst_base_wb = !w[24] || w[21];
				e.is_imm = !w[25];
				if (!w[25]) begin
					e.imm_value = 32'(w[11:0]);
				end else begin
					e.rm = w[3:0];
					e.shift = shift_op'(w[6:5]);
					e.shift_imm = w[11:7];
				end
			end
			GROUP_MUL: begin
				e.rd = w[19:16];
				e.rs = w[11:8];
				e.rm = w[3:0];
				e.mul_accumulate = w[21];
				if (w[21])
					e.rn = w[15:12];
				e.writeback = 1'b1;
				e.update_flags = w[20];
				e.undefined = w[19:16] == 4'hf || w[11:8] == 4'hf || w[3:0] == 4'hf
				              || (w[21] && w[15:12] == 4'hf);
			end
			GROUP_BRANCH: begin
				e.branch_offset = 32'($signed(w[23:0])) << 2;
				e.link = w[24];
			end
			default: begin
			end
		endcase
		return e;
	endfunction

	task automatic compare_fields(input word w);
		dec_fields e;
		e = ref_decode(w);
		check_value("group", 32'(group), 32'(e.group));
		check_value("cond", 32'(cond), 32'(e.cond));
		check_value("undefined", 32'(undefined), 32'(e.undefined));
		check_value("conditional", 32'(conditional), 32'(e.conditional));
		check_value("alu", 32'(alu), 32'(e.alu));
		check_value("rd", 32'(rd), 32'(e.rd));
		check_value("rn", 32'(rn), 32'(e.rn));
		check_value("rm", 32'(rm), 32'(e.rm));
		check_value("rs", 32'(rs), 32'(e.rs));
		check_value("is_imm", 32'(is_imm), 32'(e.is_imm));
		check_value("imm_value", imm_value, e.imm_value);
		check_value("shift", 32'(shift), 32'(e.shift));
		check_value("shift_imm", 32'(shift_imm), 32'(e.shift_imm));
		check_value("shift_by_reg", 32'(shift_by_reg), 32'(e.shift_by_reg));
		check_value("writeback", 32'(writeback), 32'(e.writeback));
		check_value("update_flags", 32'(update_flags), 32'(e.update_flags));
		check_value("branch_offset", branch_offset, e.branch_offset);
		check_value("link", 32'(link), 32'(e.link));
		check_value("ldst_load", 32'(ldst_load), 32'(e.ldst_load));
		check_value("ldst_byte", 32'(ldst_byte), 32'(e.ldst_byte));
		check_value("ldst_up", 32'(ldst_up), 32'(e.ldst_up));
		check_value("ldst_pre", 32'(ldst_pre), 32'(e.ldst_pre));
		check_value("ldst_base_wb", 32'(ldst_base_wb), 32'(e.ldst_base_wb));
		check_value("mul_accumulate", 32'(mul_accumulate), 32'(e.mul_accumulate));
	endtask

	// random word with a group pattern forced in most of the time.
	function automatic word make_insn();
		word w;
		w = $urandom;
		case ($urandom % 8)
			0: w[27:26] = 2'b00;
			1: w[27:25] = 3'b001;
			2: w[27:25] = 3'b101;
			3: w[27:26] = 2'b01;
			4: begin
				w[27:22] = 6'd0;
				w[7:4] = 4'b1001;
			end
			5: w[27:24] = 4'b1111;
			default: begin
			end
		endcase
		if ($urandom % 4 == 0)
			w[31:28] = cond_al;
		return w;
	endfunction

	initial begin
		void'($urandom(32'hb608));
		rst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		stall = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("dec_valid after reset", 32'(dec_valid), 32'd0);
		check_value("insn_ready after reset", 32'(insn_ready), 32'd1);
		while (sent < num_insns) begin
			stall = $urandom % 4 == 0;
			insn_valid = $urandom % 4 != 0;
			insn = make_insn();
			if (insn_valid && !stall)
				sent++;
			@(negedge clk);
		end
		insn_valid = 1'b0;
		stall = 1'b0;
		while (checked < num_insns)
			@(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

	// valid bits of the two registers are modelled here to catch lost items and bubbles.
	initial begin
		logic slot_v, out_v, advanced, in_reset;
		slot_v = 1'b0;
		out_v = 1'b0;
		forever begin
			@(posedge clk);
			in_reset = !rst_n;
			advanced = !stall;
			if (in_reset) begin
				slot_v = 1'b0;
				out_v = 1'b0;
			end else if (!stall) begin
				out_v = slot_v;
				slot_v = insn_valid;
				if (insn_valid)
					expected_q.push_back(insn);
			end
			@(negedge clk);
			if (!in_reset) begin
				check_value("dec_valid", 32'(dec_valid), 32'(out_v));
				if (advanced && dec_valid) begin
					compare_fields(expected_q.pop_front());
					checked++;
				end
			end
		end
	end

	initial begin
		#(num_insns * clk_period * 8);
		$display("timeout: the stage stopped delivering decoded instructions.");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

// File: dv/core_decode_props.sv
module core_decode_props
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,
	input  logic                      insn_ready,
	input  logic                      dec_valid,
	input  core_uarch_pkg::insn_group group,
	input  core_uarch_pkg::reg_num    rd,
	input  core_uarch_pkg::word       imm_value,
	input  core_uarch_pkg::word       branch_offset,
	input  logic                      writeback,
	input  logic                      undefined
);

	valid_holds: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(dec_valid))
		else $error("dec_valid changed during a stall.");

	// fields are only defined once a decoded word sits in the output register.
	fields_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall && dec_valid |=> $stable(group) && $stable(rd) && $stable(imm_value)
		                       && $stable(branch_offset) && $stable(writeback)
		                       && $stable(undefined))
		else $error("decoded fields changed during a stall.");

	valid_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !dec_valid)
		else $error("dec_valid high right after reset.");

	ready_follows_stall: assert property (@(posedge clk) insn_ready == !stall)
		else $error("insn_ready is not the inverse of stall.");

endmodule

bind core_decode_stage core_decode_props i_props (.*);

// File: verilog/core_decode_stage.sv
module core_decode_stage
(
	input  logic                      clk,
	input  logic                      rst_n,

	input  core_uarch_pkg::word       insn,
	input  logic                      insn_valid,
	input  logic                      stall,
	output logic                      insn_ready,

	output logic                      dec_valid,
	output core_uarch_pkg::insn_group group,
	output core_uarch_pkg::cond_code  cond,
	output logic                      undefined,
	output logic                      conditional,
	output core_uarch_pkg::alu_op     alu,
	output core_uarch_pkg::reg_num    rd, rn, rm, rs,
	output logic                      is_imm,
	output core_uarch_pkg::word       imm_value,
	output core_uarch_pkg::shift_op   shift,
	output logic [4:0]                shift_imm,
	output logic                      shift_by_reg,
	output logic                      writeback,
	output logic                      update_flags,
	output core_uarch_pkg::word       branch_offset,
	output logic                      link,
	output logic                      ldst_load, ldst_byte, ldst_up, ldst_pre, ldst_base_wb,
	output logic                      mul_accumulate
);

	import core_uarch_pkg::*;

	logic slot_valid;
	word slot_insn;

	insn_group d_group;
	cond_code d_cond;
	alu_op d_alu;
	reg_num d_rd, d_rn, d_rm, d_rs;
	word d_imm_value, d_branch_offset;
	shift_op d_shift;
	logic [4:0] d_shift_imm;
	logic d_undefined, d_conditional, d_is_imm, d_shift_by_reg, d_writeback, d_update_flags;
	logic d_link, d_ldst_load, d_ldst_byte, d_ldst_up, d_ldst_pre, d_ldst_base_wb;
	logic d_mul_accumulate;

	// both registers move together, so a stall freezes the whole stage.
	assign insn_ready = !stall;

	core_decode decoder
	(
		.insn(slot_insn),
		.group(d_group),
		.cond(d_cond),
		.undefined(d_undefined),
		.conditional(d_conditional),
		.alu(d_alu),
		.rd(d_rd),
		.rn(d_rn),
		.rm(d_rm),
		.rs(d_rs),
		.is_imm(d_is_imm),
		.imm_value(d_imm_value),
		.shift(d_shift),
		.shift_imm(d_shift_imm),
		.shift_by_reg(d_shift_by_reg),
		.writeback(d_writeback),
		.update_flags(d_update_flags),
		.branch_offset(d_branch_offset),
		.link(d_link),
		.ldst_load(d_ldst_load),
		.ldst_byte(d_ldst_byte),
		.ldst_up(d_ldst_up),
		.ldst_pre(d_ldst_pre),
		.ldst_base_wb(d_ldst_base_wb),
		.mul_accumulate(d_mul_accumulate)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			slot_valid <= 1'b0;
			dec_valid <= 1'b0;
		end else if (!stall) begin
			slot_valid <= insn_valid; // a cycle without insn_valid becomes a bubble.
			dec_valid <= slot_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			slot_insn <= insn;
			group <= d_group;
			cond <= d_cond;
			undefined <= d_undefined;
			conditional <= d_conditional;
			alu <= d_alu;
			rd <= d_rd;
			rn <= d_rn;
			rm <= d_rm;
			rs <= d_rs;
			is_imm <= d_is_imm;
			imm_value <= d_imm_value;
			shift <= d_shift;
			shift_imm <= d_shift_imm;
			shift_by_reg <= d_shift_by_reg;
			writeback <= d_writeback;
			update_flags <= d_update_flags;
			branch_offset <= d_branch_offset;
			link <= d_link;
			ldst_load <= d_ldst_load;
			ldst_byte <= d_ldst_byte;
			ldst_up <= d_ldst_up;
			ldst_pre <= d_ldst_pre;
			ldst_base_wb <= d_ldst_base_wb;
			mul_accumulate <= d_mul_accumulate;
		end
	end

endmodule

// File: verilog/core_decode.sv
module core_decode
(
	input  core_uarch_pkg::word       insn,

	output core_uarch_pkg::insn_group group,
	output core_uarch_pkg::cond_code  cond,
	output logic                      undefined,
	output logic                      conditional,
	output core_uarch_pkg::alu_op     alu,
	output core_uarch_pkg::reg_num    rd, rn, rm, rs,
	output logic                      is_imm,
	output core_uarch_pkg::word       imm_value,
	output core_uarch_pkg::shift_op   shift,
	output logic [4:0]                shift_imm,
	output logic                      shift_by_reg,
	output logic                      writeback,
	output logic                      update_flags,
	output core_uarch_pkg::word       branch_offset,
	output logic                      link,
	output logic                      ldst_load, ldst_byte, ldst_up, ldst_pre, ldst_base_wb,
	output logic                      mul_accumulate
);

	import core_uarch_pkg::*;

	logic mux_undefined;

	core_decode_mux mux
	(
		.undefined(mux_undefined),
		.*
	);

	logic snd_is_imm, snd_shift_by_reg, snd_undefined;
	word snd_imm;
	shift_op snd_shift;
	logic [4:0] snd_shift_imm;
	reg_num snd_rm, snd_rs;

	core_decode_snd snd_operand
	(
		.insn(insn),
		.is_imm(snd_is_imm),
		.imm_value(snd_imm),
		.shift(snd_shift),
		.shift_imm(snd_shift_imm),
		.shift_by_reg(snd_shift_by_reg),
		.rm(snd_rm),
		.rs(snd_rs),
		.snd_undefined(snd_undefined)
	);

	alu_op data_alu;
	reg_num data_rd, data_rn;
	logic data_writeback, data_update_flags;

	core_decode_data group_data
	(
		.insn(insn),
		.alu(data_alu),
		.rd(data_rd),
		.rn(data_rn),
		.writeback(data_writeback),
		.update_flags(data_update_flags)
	);

	reg_num single_rd, single_rn;
	logic single_load, single_byte, single_up, single_pre, single_base_wb, single_is_imm;
	word single_imm;

	core_decode_ldst_single group_ldst_single
	(
		.insn(insn),
		.rd(single_rd),
		.rn(single_rn),
		.load(single_load),
		.byte_access(single_byte),
		.up(single_up),
		.pre(single_pre),
		.base_wb(single_base_wb),
		.ldst_is_imm(single_is_imm),
		.ldst_imm(single_imm)
	);

	reg_num mul_rd, mul_rn, mul_rs, mul_rm;
	logic mul_acc, mul_update_flags, mul_undefined_regs;

	core_decode_mul group_mul
	(
		.insn(insn),
		.rd(mul_rd),
		.rn(mul_rn),
		.rs(mul_rs),
		.rm(mul_rm),
		.accumulate(mul_acc),
		.update_flags(mul_update_flags),
		.undefined_regs(mul_undefined_regs)
	);

	assign undefined = mux_undefined
	                || (group == GROUP_DATA && snd_undefined)
	                || (group == GROUP_MUL && mul_undefined_regs);

	// word offset, so the 24 bit field is shifted by two before use.
	assign branch_offset = group == GROUP_BRANCH ? {{6{insn[23]}}, insn[23:0], 2'b00} : '0;
	assign link = group == GROUP_BRANCH && insn[24];

	assign ldst_load = group == GROUP_LDST && single_load;
	assign ldst_byte = group == GROUP_LDST && single_byte;
	assign ldst_up = group == GROUP_LDST && single_up;
	assign ldst_pre = group == GROUP_LDST && single_pre;
	assign ldst_base_wb = group == GROUP_LDST && single_base_wb;

	assign mul_accumulate = group == GROUP_MUL && mul_acc;

	always_comb begin
		alu = ALU_AND;
		rd = '0;
		rn = '0;
		rm = '0;
		rs = '0;
		is_imm = 1'b0;
		imm_value = '0;
		shift = SHIFT_LSL;
		shift_imm = '0;
		shift_by_reg = 1'b0;
		writeback = 1'b0;
		update_flags = 1'b0;

		case (group)
			GROUP_DATA: begin
				alu = data_alu;
				rd = data_rd;
				rn = data_rn;
				writeback = data_writeback;
				update_flags = data_update_flags;
				is_imm = snd_is_imm;
				if (snd_is_imm) begin
					imm_value = snd_imm;
				end else begin
					rm = snd_rm;
					rs = snd_rs;
					shift = snd_shift;
					shift_imm = snd_shift_imm;
					shift_by_reg = snd_shift_by_reg;
				end
			end
			GROUP_LDST: begin
				rd = single_rd;
				rn = single_rn;
				writeback = single_load; // only loads write rd.
				is_imm = single_is_imm;
				if (single_is_imm) begin
					imm_value = single_imm;
				end else begin
					// the register offset reuses the shifter fields.
					rm = snd_rm;
					shift = snd_shift;
					shift_imm = snd_shift_imm;
				end
			end
			GROUP_MUL: begin
				rd = mul_rd;
				rn = mul_rn;
				rm = mul_rm;
				rs = mul_rs;
				writeback = 1'b1;
				update_flags = mul_update_flags;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: verilog/core_decode_mul.sv
module core_decode_mul
(
	input  core_uarch_pkg::word    insn,

	output core_uarch_pkg::reg_num rd,
	output core_uarch_pkg::reg_num rn,
	output core_uarch_pkg::reg_num rs,
	output core_uarch_pkg::reg_num rm,
	output logic                   accumulate,
	output logic                   update_flags,
	output logic                   undefined_regs
);

	import core_uarch_pkg::*;

	assign accumulate = insn[21];
	assign update_flags = insn[20];

	// the destination field sits where data processing keeps rn.
	assign rd = insn[19:16];
	assign rn = accumulate ? insn[15:12] : 4'd0;
	assign rs = insn[11:8];
	assign rm = insn[3:0];

	assign undefined_regs = rd == reg_pc || rs == reg_pc || rm == reg_pc
	                     || (accumulate && rn == reg_pc);

endmodule

// File: verilog/core_decode_ldst_single.sv
module core_decode_ldst_single
(
	input  core_uarch_pkg::word    insn,

	output core_uarch_pkg::reg_num rd,
	output core_uarch_pkg::reg_num rn,
	output logic                   load,
	output logic                   byte_access,
	output logic                   up,
	output logic                   pre,
	output logic                   base_wb,
	output logic                   ldst_is_imm,
	output core_uarch_pkg::word    ldst_imm
);

	import core_uarch_pkg::*;

	assign pre = insn[24];
	assign up = insn[23];
	assign byte_access = insn[22];
	assign load = insn[20];

	assign rn = insn[19:16];
	assign rd = insn[15:12];

	assign base_wb = !pre || insn[21]; // post-indexed forms always update the base.

	// the I bit is inverted here compared to data processing.
	assign ldst_is_imm = !insn[25];
	assign ldst_imm = word'(insn[11:0]);

endmodule

// File: verilog/core_decode_data.sv
module core_decode_data
(
	input  core_uarch_pkg::word    insn,

	output core_uarch_pkg::alu_op  alu,
	output core_uarch_pkg::reg_num rd,
	output core_uarch_pkg::reg_num rn,
	output logic                   writeback,
	output logic                   update_flags
);

	import core_uarch_pkg::*;

	logic compare;

	assign alu = alu_op'(insn[24:21]);
	assign rn = insn[19:16];
	assign rd = insn[15:12];

	// compares only set flags and never write rd.
	assign compare = alu inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN};

	assign writeback = !compare;
	assign update_flags = insn[20] || compare;

endmodule

// File: verilog/core_decode_snd.sv
module core_decode_snd
(
	input  core_uarch_pkg::word     insn,

	output logic                    is_imm,
	output core_uarch_pkg::word     imm_value,
	output core_uarch_pkg::shift_op shift,
	output logic [4:0]              shift_imm,
	output logic                    shift_by_reg,
	output core_uarch_pkg::reg_num  rm,
	output core_uarch_pkg::reg_num  rs,
	output logic                    snd_undefined
);

	import core_uarch_pkg::*;

	word imm_base;
	logic [4:0] rot;
	logic [63:0] imm_pair;

	assign is_imm = insn[25];

	// an 8 bit value rotated right by twice the 4 bit field.
	assign imm_base = {24'b0, insn[7:0]};
	assign rot = {insn[11:8], 1'b0};
	assign imm_pair = {imm_base, imm_base} >> rot;
	assign imm_value = imm_pair[31:0];

	assign shift = shift_op'(insn[6:5]);
	assign shift_by_reg = insn[4];
	assign rm = insn[3:0];
	assign shift_imm = shift_by_reg ? 5'd0 : insn[11:7];
	assign rs = shift_by_reg ? insn[11:8] : 4'd0;

	assign snd_undefined = !is_imm && shift_by_reg && (rm == reg_pc || rs == reg_pc);

endmodule

// File: verilog/core_decode_mux.sv
module core_decode_mux
(
	input  core_uarch_pkg::word       insn,

	output core_uarch_pkg::insn_group group,
	output core_uarch_pkg::cond_code  cond,
	output logic                      undefined,
	output logic                      conditional
);

	import core_uarch_pkg::*;

	logic is_mul, ext_space, misc_space, media_space;

	assign cond = insn[31:28];
	assign conditional = cond != cond_al;

	assign is_mul = insn[27:22] == 6'b000000 && insn[7:4] == mul_tag;

	// halfword and swap live where a register shift would have bit 7 and bit 4 set.
	assign ext_space = !insn[25] && insn[7] && insn[4];

	// compares without the S bit encode PSR transfers and other extensions.
	assign misc_space = insn[24:23] == 2'b10 && !insn[20];

	// a register offset with bit 4 set is not a load or store.
	assign media_space = insn[25] && insn[4];

	always_comb begin
		if (is_mul)
			group = GROUP_MUL;
		else if (insn[27:26] == 2'b00 && !ext_space && !misc_space)
			group = GROUP_DATA;
		else if (insn[27:26] == 2'b01 && !media_space)
			group = GROUP_LDST;
		else if (insn[27:25] == 3'b101)
			group = GROUP_BRANCH;
		else if (insn[27:24] == 4'b1111)
			group = GROUP_SWI;
		else
			group = GROUP_UNDEF;

		if (cond == cond_nv)
			group = GROUP_UNDEF; // the never condition is not executed on this core.
	end

	assign undefined = group == GROUP_UNDEF;

endmodule

// File: verilog/core_uarch_pkg.sv
package core_uarch_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	// the top nibble of every instruction, EQ is 0 and NV is 15.
	typedef logic [3:0] cond_code;

	typedef enum logic [3:0] {
		ALU_AND,
		ALU_EOR,
		ALU_SUB,
		ALU_RSB,
		ALU_ADD,
		ALU_ADC,
		ALU_SBC,
		ALU_RSC,
		ALU_TST, // first of the four compares.
		ALU_TEQ,
		ALU_CMP,
		ALU_CMN,
		ALU_ORR,
		ALU_MOV,
		ALU_BIC,
		ALU_MVN
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR
	} shift_op;

	// one group per sub-decoder, undefined catches everything else.
	typedef enum logic [2:0] {
		GROUP_DATA,
		GROUP_BRANCH,
		GROUP_LDST,
		GROUP_MUL,
		GROUP_SWI,
		GROUP_UNDEF
	} insn_group;

	localparam cond_code cond_al = 4'b1110;
	localparam cond_code cond_nv = 4'b1111;

	localparam reg_num reg_pc = 4'd15;

	// bits 7..4 of a multiply, which sits inside the data processing space.
	localparam logic [3:0] mul_tag = 4'b1001;

endpackage
